// File: rtl/snake_pkg.sv
package snake_pkg;

    typedef logic [9:0]  coord_t;     // One screen axis
    typedef logic [15:0] color_t;     // RGB565
    typedef logic [5:0]  score_t;
    typedef logic [3:0]  dir_t;       // One-hot direction

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    typedef enum logic [3:0] {
        st_start = 4'b0001,
        st_speed = 4'b0010,
        st_play  = 4'b0100,
        st_end   = 4'b1000
    } game_state_e;

    localparam dir_t dir_right = 4'b0001;
    localparam dir_t dir_left  = 4'b0010;
    localparam dir_t dir_down  = 4'b0100;
    localparam dir_t dir_up    = 4'b1000;

    localparam coord_t h_disp = 10'd640;
    localparam coord_t v_disp = 10'd480;
    localparam coord_t border = 10'd16;
    localparam coord_t tile   = 10'd16;     // Segment size and move step

    localparam int init_segments = 4;
    localparam int max_segments  = 16;

    typedef logic [max_segments-1:0] seg_mask_t;
    typedef point_t [max_segments-1:0] body_t;

    localparam point_t head_start  = '{x: 10'd96, y: 10'd48};
    localparam point_t apple_start = '{x: 10'd352, y: 10'd256};

    localparam coord_t apple_cnt_start = 10'd16;
    localparam coord_t apple_cnt_wrap  = 10'd32;

    localparam color_t c_border = 16'hF800;
    localparam color_t c_apple  = 16'hFFE0;
    localparam color_t c_head   = 16'h0400;
    localparam color_t c_body   = 16'h001F;
    localparam color_t c_blank  = 16'h0000;

    // True when p lies in the 16x16 tile whose top-left corner is org
    function automatic logic tile_hit(point_t p, point_t org);
        logic [10:0] x_end;
        logic [10:0] y_end;
        x_end = {1'b0, org.x} + 11'(tile);    // Extra bit keeps the edge from wrapping
        y_end = {1'b0, org.y} + 11'(tile);
        return (p.x >= org.x) && ({1'b0, p.x} < x_end) &&
               (p.y >= org.y) && ({1'b0, p.y} < y_end);
    endfunction

endpackage

// File: rtl/move_tick_timer.sv
`timescale 1ns/1ps

module move_tick_timer
    import snake_pkg::*;
#(
    parameter int fast_period = 3_750_000,
    parameter int slow_period = 6_250_000
) (
    input  logic vga_clk_25,
    input  logic rst_n,
    input  logic speed_m,
    output logic move_tick
);

    logic [23:0] period;
    logic [23:0] cnt;

    assign period = speed_m ? 24'(slow_period) : 24'(fast_period);

    // At-or-above compare recovers when speed drops to the shorter period
    always_ff @(posedge vga_clk_25 or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            move_tick <= 1'b0;
        end else if (cnt >= period - 24'd1) begin
            cnt       <= '0;
            move_tick <= 1'b1;      // High for one cycle only
        end else begin
            cnt       <= cnt + 24'd1;
            move_tick <= 1'b0;
        end
    end

endmodule

// File: rtl/snake_body.sv
`timescale 1ns/1ps

module snake_body
    import snake_pkg::*;
(
    input  logic        vga_clk_25,
    input  logic        rst_n,
    input  logic        move_tick,
    input  game_state_e state_m,
    input  dir_t        move_dirt,
    input  score_t      score,
    output point_t      head,
    output body_t       body,
    output seg_mask_t   seg_valid
);

    logic [6:0] grow_cnt;
    logic [6:0] active_cnt;
    point_t     next_head;
    logic       dir_ok;
    logic       step;

    function automatic body_t start_layout();
        body_t b;
        b = '0;                     // Unused segments park at (0,0)
        for (int i = 0; i < init_segments; i++) begin
            b[i].x = head_start.x - coord_t'(tile * (i + 1));
            b[i].y = head_start.y;
        end
        return b;
    endfunction

    // Active count saturates at the array size
    assign grow_cnt   = 7'(init_segments) + 7'(score);
    assign active_cnt = (grow_cnt > 7'(max_segments)) ? 7'(max_segments) : grow_cnt;

    always_comb begin
        for (int i = 0; i < max_segments; i++) begin
            seg_valid[i] = (7'(i) < active_cnt);
        end
    end

    always_comb begin
        next_head = head;
        dir_ok    = 1'b1;
        case (move_dirt)
            dir_right: next_head.x = head.x + tile;
            dir_left:  next_head.x = head.x - tile;
            dir_down:  next_head.y = head.y + tile;
            dir_up:    next_head.y = head.y - tile;
            default:   dir_ok = 1'b0;           // Not one-hot, stand still
        endcase
    end

    assign step = move_tick && (state_m == st_play) && dir_ok;

    always_ff @(posedge vga_clk_25 or negedge rst_n) begin
        if (!rst_n) begin
            head <= head_start;
            body <= start_layout();
        end else if (state_m == st_start) begin
            head <= head_start;
            body <= start_layout();
        end else if (step) begin
            head    <= next_head;
            body[0] <= head;
            for (int i = 1; i < max_segments; i++) begin
                if (seg_valid[i]) begin
                    body[i] <= body[i-1];       // Tail beyond active count holds
                end
            end
        end
    end

endmodule

// File: rtl/apple_unit.sv
`timescale 1ns/1ps

module apple_unit
    import snake_pkg::*;
(
    input  logic        vga_clk_25,
    input  logic        rst_n,
    input  game_state_e state_m,
    input  point_t      head,
    output point_t      apple,
    output score_t      score
);

    logic   eat;
    logic   hit;
    coord_t x_cnt;
    coord_t y_cnt;

    assign hit = tile_hit(head, apple);

    // Flag guards the score so one overlap counts once
    always_ff @(posedge vga_clk_25 or negedge rst_n) begin
        if (!rst_n) begin
            eat   <= 1'b0;
            score <= '0;
        end else if (state_m == st_start) begin
            eat   <= 1'b0;
            score <= '0;
        end else if (state_m == st_play) begin
            eat <= hit;
            if (hit && !eat) begin
                score <= score + score_t'(1);
            end
        end
    end

    // Stepping counters give a pseudo-random spot for the next apple
    always_ff @(posedge vga_clk_25 or negedge rst_n) begin
        if (!rst_n) begin
            apple <= apple_start;
            x_cnt <= apple_cnt_start;
            y_cnt <= apple_cnt_start;
        end else if (state_m == st_start) begin
            apple <= apple_start;
        end else if (state_m == st_play) begin
            if (eat) begin
                apple <= '{x: x_cnt, y: y_cnt};
            end else if (x_cnt > h_disp - border - tile - tile) begin
                x_cnt <= apple_cnt_wrap;
            end else if (y_cnt > v_disp - border - tile - tile) begin
                y_cnt <= apple_cnt_wrap;
            end else begin
                x_cnt <= x_cnt + tile;
                y_cnt <= y_cnt + tile;
            end
        end
    end

endmodule

// File: rtl/collision_check.sv
`timescale 1ns/1ps

module collision_check
    import snake_pkg::*;
(
    input  logic        vga_clk_25,
    input  logic        rst_n,
    input  game_state_e state_m,
    input  point_t      head,
    input  body_t       body,
    input  seg_mask_t   seg_valid,
    output logic        game_over
);

    logic meet_wall;
    logic meet_body;
    logic wall_hit;
    logic body_hit;

    // Head tile must stay fully inside the border
    assign wall_hit = (head.x < border) || (head.x > h_disp - border - tile) ||
                      (head.y < border) || (head.y > v_disp - border - tile);

    always_comb begin
        body_hit = 1'b0;
        for (int i = 0; i < max_segments; i++) begin
            if (seg_valid[i] && tile_hit(head, body[i])) begin
                body_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge vga_clk_25 or negedge rst_n) begin
        if (!rst_n) begin
            meet_wall <= 1'b0;
            meet_body <= 1'b0;
        end else if (state_m == st_start) begin
            meet_wall <= 1'b0;
            meet_body <= 1'b0;
        end else if (state_m == st_play) begin
            meet_wall <= wall_hit;
            meet_body <= body_hit;
        end
    end

    assign game_over = meet_wall || meet_body;

endmodule

// File: rtl/pixel_render.sv
`timescale 1ns/1ps

module pixel_render
    import snake_pkg::*;
(
    input  logic      vga_clk_25,
    input  logic      rst_n,
    input  point_t    pixel_pos,
    input  point_t    head,
    input  body_t     body,
    input  seg_mask_t seg_valid,
    input  point_t    apple,
    output color_t    pixel_data
);

    logic on_border;
    logic on_apple;
    logic on_head;
    logic on_body;

    assign on_border = (pixel_pos.x < border) || (pixel_pos.x >= h_disp - border) ||
                       (pixel_pos.y < border) || (pixel_pos.y >= v_disp - border);
    assign on_apple  = tile_hit(pixel_pos, apple);
    assign on_head   = tile_hit(pixel_pos, head);

    always_comb begin
        on_body = 1'b0;
        for (int i = 0; i < max_segments; i++) begin
            if (seg_valid[i] && tile_hit(pixel_pos, body[i])) begin
                on_body = 1'b1;
            end
        end
    end

    // Earlier layers cover later ones
    always_ff @(posedge vga_clk_25 or negedge rst_n) begin
        if (!rst_n) begin
            pixel_data <= c_blank;
        end else if (on_border) begin
            pixel_data <= c_border;
        end else if (on_apple) begin
            pixel_data <= c_apple;
        end else if (on_head) begin
            pixel_data <= c_head;
        end else if (on_body) begin
            pixel_data <= c_body;
        end else begin
            pixel_data <= c_blank;
        end
    end

endmodule

// File: rtl/snake_game.sv
`timescale 1ns/1ps

module snake_game
    import snake_pkg::*;
#(
    parameter int fast_period = 3_750_000,
    parameter int slow_period = 6_250_000
) (
    input  logic        vga_clk_25,
    input  logic        rst_n,
    input  point_t      pixel_pos,
    input  game_state_e state_m,
    input  logic        speed_m,
    input  dir_t        move_dirt,
    output logic        game_over,
    output score_t      game_score,
    output color_t      pixel_data
);

    logic      move_tick;
    point_t    head;
    body_t     body;
    seg_mask_t seg_valid;
    point_t    apple;
    score_t    score;

    move_tick_timer #(
        .fast_period (fast_period),
        .slow_period (slow_period)
    ) u_timer (
        .vga_clk_25 (vga_clk_25),
        .rst_n      (rst_n),
        .speed_m    (speed_m),
        .move_tick  (move_tick)
    );

    snake_body u_body (
        .vga_clk_25 (vga_clk_25),
        .rst_n      (rst_n),
        .move_tick  (move_tick),
        .state_m    (state_m),
        .move_dirt  (move_dirt),
        .score      (score),
        .head       (head),
        .body       (body),
        .seg_valid  (seg_valid)
    );

    apple_unit u_apple (
        .vga_clk_25 (vga_clk_25),
        .rst_n      (rst_n),
        .state_m    (state_m),
        .head       (head),
        .apple      (apple),
        .score      (score)
    );

    collision_check u_collide (
        .vga_clk_25 (vga_clk_25),
        .rst_n      (rst_n),
        .state_m    (state_m),
        .head       (head),
        .body       (body),
        .seg_valid  (seg_valid),
        .game_over  (game_over)
    );

    pixel_render u_render (
        .vga_clk_25 (vga_clk_25),
        .rst_n      (rst_n),
        .pixel_pos  (pixel_pos),
        .head       (head),
        .body       (body),
        .seg_valid  (seg_valid),
        .apple      (apple),
        .pixel_data (pixel_data)
    );

    assign game_score = score;

endmodule

// File: test/snake_checker.sv
`timescale 1ns/1ps

module snake_checker
    import snake_pkg::*;
#(
    parameter int fast_period = 40,
    parameter int slow_period = 70
) (
    input logic        vga_clk_25,
    input logic        rst_n,
    input point_t      pixel_pos,
    input game_state_e state_m,
    input logic        speed_m,
    input dir_t        move_dirt,
    input logic        game_over,
    input score_t      game_score,
    input color_t      pixel_data
);

    int     tick_cnt;
    logic   tick;
    point_t m_head;
    point_t m_body [max_segments];
    point_t m_apple;
    score_t m_score;
    logic   m_eat;
    coord_t x_cnt;
    coord_t y_cnt;
    logic   m_wall;
    logic   m_self;
    color_t m_pix;
    logic   started = 1'b0;
    int     err_cnt = 0;
    int     chk_cnt = 0;

    function automatic logic in_tile(point_t p, point_t org);
        return (int'(p.x) >= int'(org.x)) && (int'(p.x) < int'(org.x) + 16) &&
               (int'(p.y) >= int'(org.y)) && (int'(p.y) < int'(org.y) + 16);
    endfunction

    function automatic int active_segs(score_t s);
        return (int'(s) + 4 > 16) ? 16 : int'(s) + 4;
    endfunction

    task automatic load_start();
        m_head = '{x: 10'd96, y: 10'd48};
        for (int i = 0; i < max_segments; i++) begin
            m_body[i] = '0;
            if (i < 4) begin
                m_body[i].x = coord_t'(96 - 16 * (i + 1));    // One tile further left each
                m_body[i].y = 10'd48;
            end
        end
    endtask

    task automatic reset_model();
        load_start();
        tick_cnt = 0;
        tick     = 1'b0;
        m_apple  = '{x: 10'd352, y: 10'd256};
        m_score  = '0;
        m_eat    = 1'b0;
        x_cnt    = 10'd16;
        y_cnt    = 10'd16;
        m_wall   = 1'b0;
        m_self   = 1'b0;
        m_pix    = c_blank;
    endtask

    // All decisions use the values held before this edge
    task automatic model_edge();
        int     act;
        logic   on_body;
        logic   self_hit;
        logic   eat_now;
        point_t nh;
        act      = active_segs(m_score);
        on_body  = 1'b0;
        self_hit = 1'b0;
        for (int i = 0; i < act; i++) begin
            on_body  = on_body | in_tile(pixel_pos, m_body[i]);
            self_hit = self_hit | in_tile(m_head, m_body[i]);
        end
        if (int'(pixel_pos.x) < 16 || int'(pixel_pos.x) >= 624 ||
            int'(pixel_pos.y) < 16 || int'(pixel_pos.y) >= 464) begin
            m_pix = c_border;
        end else if (in_tile(pixel_pos, m_apple)) begin
            m_pix = c_apple;
        end else if (in_tile(pixel_pos, m_head)) begin
            m_pix = c_head;
        end else begin
            m_pix = on_body ? c_body : c_blank;
        end
        if (state_m == st_start) begin
            load_start();
            m_apple = '{x: 10'd352, y: 10'd256};
            m_score = '0;
            m_eat   = 1'b0;
            m_wall  = 1'b0;
            m_self  = 1'b0;
        end else if (state_m == st_play) begin
            m_wall = int'(m_head.x) < 16 || int'(m_head.x) > 608 ||
                     int'(m_head.y) < 16 || int'(m_head.y) > 448;
            m_self  = self_hit;
            eat_now = in_tile(m_head, m_apple);
            if (m_eat) begin
                m_apple = '{x: x_cnt, y: y_cnt};
            end else if (int'(x_cnt) > 592) begin
                x_cnt = 10'd32;
            end else if (int'(y_cnt) > 432) begin
                y_cnt = 10'd32;
            end else begin
                x_cnt = x_cnt + 10'd16;
                y_cnt = y_cnt + 10'd16;
            end
            if (eat_now && !m_eat) begin
                m_score = m_score + 6'd1;
            end
            m_eat = eat_now;
            nh    = m_head;
            case (move_dirt)
                dir_right: nh.x = m_head.x + 10'd16;
                dir_left:  nh.x = m_head.x - 10'd16;
                dir_down:  nh.y = m_head.y + 10'd16;
                dir_up:    nh.y = m_head.y - 10'd16;
                default:   nh = m_head;
            endcase
            if (tick && $onehot(move_dirt)) begin
                for (int i = max_segments - 1; i > 0; i--) begin
                    if (i < act) begin
                        m_body[i] = m_body[i-1];
                    end
                end
                m_body[0] = m_head;
                m_head    = nh;
            end
        end
        if (tick_cnt >= (speed_m ? slow_period : fast_period) - 1) begin
            tick_cnt = 0;
            tick     = 1'b1;
        end else begin
            tick_cnt = tick_cnt + 1;
            tick     = 1'b0;
        end
    endtask

    task automatic compare(string what, int got, int exp);
        chk_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("error at %0t ns: %s is 0x%0h, model expects 0x%0h",
                     $time, what, got, exp);
        end
    endtask

    always @(posedge vga_clk_25 or negedge rst_n) begin
        if (!rst_n) begin
            reset_model();
        end else begin
            model_edge();
        end
        started = 1'b1;
    end

    always @(negedge vga_clk_25) begin
        if (started) begin                        // Outputs settled mid-cycle
            compare("game_over", int'(game_over), int'(m_wall | m_self));
            compare("game_score", int'(game_score), int'(m_score));
            compare("pixel_data", int'(pixel_data), int'(m_pix));
        end
    end

endmodule

// File: test/tb_snake_game.sv
`timescale 1ns/1ps

module tb_snake_game
    import snake_pkg::*;
();

    localparam int clk_period  = 100;
    localparam int n_games     = 8;
    localparam int play_limit  = 3000;
    localparam int game_cycles = 3200;

    logic        vga_clk_25;
    logic        rst_n;
    point_t      pixel_pos;
    game_state_e state_m;
    logic        speed_m;
    dir_t        move_dirt;
    logic        game_over;
    score_t      game_score;
    color_t      pixel_data;

    int   cycle_cnt = 0;
    int   overs     = 0;
    logic wall_run;
    dir_t fixed_dir;

    snake_game #(
        .fast_period (40),
        .slow_period (70)
    ) uut (
        .vga_clk_25 (vga_clk_25),
        .rst_n      (rst_n),
        .pixel_pos  (pixel_pos),
        .state_m    (state_m),
        .speed_m    (speed_m),
        .move_dirt  (move_dirt),
        .game_over  (game_over),
        .game_score (game_score),
        .pixel_data (pixel_data)
    );

    snake_checker #(
        .fast_period (40),
        .slow_period (70)
    ) chk (
        .vga_clk_25 (vga_clk_25),
        .rst_n      (rst_n),
        .pixel_pos  (pixel_pos),
        .state_m    (state_m),
        .speed_m    (speed_m),
        .move_dirt  (move_dirt),
        .game_over  (game_over),
        .game_score (game_score),
        .pixel_data (pixel_data)
    );

    initial begin
        vga_clk_25 = 1'b0;
        forever #(clk_period / 2) vga_clk_25 = ~vga_clk_25;
    end

    function automatic point_t pick_pixel();
        point_t p;
        point_t org;
        int     sel;
        int     idx;
        sel = int'($urandom % 3);
        idx = int'($urandom % max_segments);
        if (cycle_cnt % 4 != 3) begin
            p.x = coord_t'($urandom % 640);
            p.y = coord_t'($urandom % 480);
        end else begin
            case (sel)
                0:       org = chk.m_head;
                1:       org = chk.m_apple;
                default: org = chk.m_body[idx];    // Inactive ones too
            endcase
            p.x = org.x + coord_t'($urandom % 16);
            p.y = org.y + coord_t'($urandom % 16);
        end
        return p;
    endfunction

    function automatic dir_t pick_dir();
        point_t h;
        point_t a;
        h = chk.m_head;
        a = chk.m_apple;
        if ($urandom % 8 == 0) begin
            return dir_t'($urandom % 16);       // Reversal and invalid codes too
        end
        if (wall_run) begin
            return fixed_dir;
        end
        if (h.x < a.x) begin
            return dir_right;
        end else if (h.x > a.x) begin
            return dir_left;
        end else if (h.y < a.y) begin
            return dir_down;
        end else if (h.y > a.y) begin
            return dir_up;
        end
        return dir_right;
    endfunction

    task automatic drive_cycle(game_state_e st, logic spd);
        @(negedge vga_clk_25);
        state_m   = st;
        speed_m   = spd;
        pixel_pos = pick_pixel();
        move_dirt = pick_dir();
        cycle_cnt++;
    endtask

    task automatic run_game(int g);
        int   cyc;
        logic spd;
        spd       = ($urandom % 2) == 1;
        wall_run  = (g % 3 == 2);                 // Straight line until a wall
        fixed_dir = dir_t'(1 << ($urandom % 4));
        repeat (4) drive_cycle(st_start, speed_m);
        repeat (4) drive_cycle(st_speed, spd);
        cyc = 0;
        do begin
            drive_cycle(st_play, spd);
            cyc++;
        end while (!game_over && cyc < play_limit);
        if (game_over) begin
            overs++;
        end
        $display("Game %0d: speed %0d, score %0d, ended by %s after %0d cycles",
                 g, spd, game_score, game_over ? "collision" : "time limit", cyc);
        repeat (8) drive_cycle(st_end, spd);
    endtask

    initial begin
        void'($urandom(21));
        rst_n     = 1'b0;
        pixel_pos = '0;
        state_m   = st_start;
        speed_m   = 1'b0;
        move_dirt = dir_right;
        wall_run  = 1'b0;
        fixed_dir = dir_right;
        repeat (16) @(posedge vga_clk_25);
        @(negedge vga_clk_25);
        rst_n = 1'b1;
        for (int g = 0; g < n_games; g++) begin
            run_game(g);
        end
        $display("Checks: %0d, errors: %0d, games ended by collision: %0d",
                 chk.chk_cnt, chk.err_cnt, overs);
        if (chk.err_cnt == 0 && chk.chk_cnt > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(n_games * game_cycles * clk_period);
        $display("The run timed out before all %0d games were played", n_games);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: vlog.f
rtl/snake_pkg.sv
rtl/move_tick_timer.sv
rtl/snake_body.sv
rtl/apple_unit.sv
rtl/collision_check.sv
rtl/pixel_render.sv
rtl/snake_game.sv
test/snake_checker.sv
test/tb_snake_game.sv

// File: Makefile
SRCS := $(shell grep -v '^+' vlog.f)

.PHONY: all run clean

all: obj_dir/Vtb_snake_game

obj_dir/Vtb_snake_game: vlog.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
		--top-module tb_snake_game -Mdir obj_dir

run: obj_dir/Vtb_snake_game
	@out="$$(./obj_dir/Vtb_snake_game)"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
